//--- hdl/core_pkg.sv
package core_pkg;

  // --------------------------------------------------
  // Widths
  // --------------------------------------------------
  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned NR_REGS    = 32;
  localparam int unsigned CSR_ADDR_W = 12;

  // Operations the decoder can produce
  typedef enum logic [2:0] {
    OP_ADD     = 3'd0,
    OP_SUB     = 3'd1,
    OP_XOR     = 3'd2,
    OP_ADDI    = 3'd3,
    OP_CSRRW   = 3'd4,
    OP_CSRRS   = 3'd5,
    OP_ECALL   = 3'd6,
    OP_ILLEGAL = 3'd7
  } op_e;

  // --------------------------------------------------
  // Instruction fields
  // --------------------------------------------------
  localparam logic [6:0] OPC_OP     = 7'h33;
  localparam logic [6:0] OPC_OP_IMM = 7'h13;
  localparam logic [6:0] OPC_SYSTEM = 7'h73;

  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_ADDI    = 3'b000;
  localparam logic [2:0] F3_PRIV    = 3'b000;
  localparam logic [2:0] F3_CSRRW   = 3'b001;
  localparam logic [2:0] F3_CSRRS   = 3'b010;

  localparam logic [6:0] F7_BASE    = 7'h00;
  localparam logic [6:0] F7_SUB     = 7'h20;

  // --------------------------------------------------
  // Machine CSRs and trap causes
  // --------------------------------------------------
  localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC    = 12'h305;
  localparam logic [CSR_ADDR_W-1:0] CSR_MSCRATCH = 12'h340;
  localparam logic [CSR_ADDR_W-1:0] CSR_MEPC     = 12'h341;
  localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE   = 12'h342;
  localparam logic [CSR_ADDR_W-1:0] CSR_MINSTRET = 12'hB02;

  localparam logic [XLEN-1:0] CAUSE_ILLEGAL_INSTR = 32'd2;
  localparam logic [XLEN-1:0] CAUSE_ECALL_M       = 32'd11;

endpackage

//--- hdl/regfile.sv
`timescale 1ns/1ps

module regfile (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic [core_pkg::REG_ADDR_W-1:0] raddr_a_i,
  input  logic [core_pkg::REG_ADDR_W-1:0] raddr_b_i,
  input  logic                            we_i,
  input  logic [core_pkg::REG_ADDR_W-1:0] waddr_i,
  input  logic [core_pkg::XLEN-1:0]       wdata_i,
  output logic [core_pkg::XLEN-1:0]       rdata_a_o,
  output logic [core_pkg::XLEN-1:0]       rdata_b_o
);

  // x0 has no storage
  logic [core_pkg::XLEN-1:0] regs_q [1:core_pkg::NR_REGS-1];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 1; i < core_pkg::NR_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && waddr_i != '0) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

//--- hdl/csr_regfile.sv
`timescale 1ns/1ps

module csr_regfile (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            csr_req_i,
  input  core_pkg::op_e                   csr_op_i,
  input  logic [core_pkg::CSR_ADDR_W-1:0] csr_addr_i,
  input  logic [core_pkg::XLEN-1:0]       csr_wdata_i,
  input  logic                            retire_i,
  input  logic                            trap_req_i,
  input  logic [core_pkg::XLEN-1:0]       trap_pc_i,
  input  logic [core_pkg::XLEN-1:0]       trap_cause_i,
  output logic [core_pkg::XLEN-1:0]       csr_rdata_o,
  output logic                            csr_illegal_o,
  output logic [core_pkg::XLEN-1:0]       mtvec_o
);

  logic [core_pkg::XLEN-1:0] mscratch_q;
  logic [core_pkg::XLEN-1:0] mtvec_q;
  logic [core_pkg::XLEN-1:0] mepc_q;
  logic [core_pkg::XLEN-1:0] mcause_q;
  logic [core_pkg::XLEN-1:0] minstret_q;
  logic                      known;
  logic                      wr_attempt;
  logic                      csr_we;
  logic [core_pkg::XLEN-1:0] wr_val;

  // Read mux, returns the value before this access
  always_comb begin
    known = 1'b1;
    case (csr_addr_i)
      core_pkg::CSR_MSCRATCH: csr_rdata_o = mscratch_q;
      core_pkg::CSR_MTVEC:    csr_rdata_o = mtvec_q;
      core_pkg::CSR_MEPC:     csr_rdata_o = mepc_q;
      core_pkg::CSR_MCAUSE:   csr_rdata_o = mcause_q;
      core_pkg::CSR_MINSTRET: csr_rdata_o = minstret_q;
      default: begin
        csr_rdata_o = '0;
        known       = 1'b0;
      end
    endcase
  end

  // CSRRS from x0 carries a zero operand and only reads
  assign wr_attempt = (csr_op_i == core_pkg::OP_CSRRW) |
                      (csr_op_i == core_pkg::OP_CSRRS && csr_wdata_i != '0);

  // minstret is read-only here
  assign csr_illegal_o = csr_req_i &
                         (~known | (wr_attempt & (csr_addr_i == core_pkg::CSR_MINSTRET)));

  assign csr_we  = csr_req_i & ~csr_illegal_o & wr_attempt;
  assign wr_val  = (csr_op_i == core_pkg::OP_CSRRW) ? csr_wdata_i : (csr_rdata_o | csr_wdata_i);
  assign mtvec_o = mtvec_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mscratch_q <= '0;
      mtvec_q    <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
      minstret_q <= '0;
    end else begin
      if (csr_we) begin
        case (csr_addr_i)
          core_pkg::CSR_MSCRATCH: mscratch_q <= wr_val;
          core_pkg::CSR_MTVEC:    mtvec_q    <= wr_val;
          core_pkg::CSR_MEPC:     mepc_q     <= wr_val;
          core_pkg::CSR_MCAUSE:   mcause_q   <= wr_val;
          default: ;
        endcase
      end
      // Trap capture
      if (trap_req_i) begin
        mepc_q   <= trap_pc_i;
        mcause_q <= trap_cause_i;
      end
      if (retire_i) begin
        minstret_q <= minstret_q + 1'b1;
      end
    end
  end

endmodule

//--- hdl/id_stage.sv
`timescale 1ns/1ps

module id_stage (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            fetch_valid_i,
  input  logic [core_pkg::XLEN-1:0]       fetch_pc_i,
  input  logic [core_pkg::XLEN-1:0]       fetch_instr_i,
  input  logic                            trap_stall_i,
  output logic                            fetch_ready_o,
  output logic                            dec_valid_o,
  output core_pkg::op_e                   dec_op_o,
  output logic [core_pkg::XLEN-1:0]       dec_pc_o,
  output logic [core_pkg::XLEN-1:0]       dec_instr_o,
  output logic [core_pkg::REG_ADDR_W-1:0] dec_rd_o,
  output logic [core_pkg::REG_ADDR_W-1:0] dec_rs1_o,
  output logic [core_pkg::REG_ADDR_W-1:0] dec_rs2_o,
  output logic [core_pkg::XLEN-1:0]       dec_imm_o,
  output logic [core_pkg::CSR_ADDR_W-1:0] dec_csr_addr_o
);

  logic [6:0]    opcode;
  logic [2:0]    funct3;
  logic [6:0]    funct7;
  logic          accept;
  core_pkg::op_e op_d;

  assign opcode = fetch_instr_i[6:0];
  assign funct3 = fetch_instr_i[14:12];
  assign funct7 = fetch_instr_i[31:25];

  // Only a trap in execute holds off fetch
  assign fetch_ready_o = ~trap_stall_i;
  assign accept        = fetch_valid_i & fetch_ready_o;

  always_comb begin
    op_d = core_pkg::OP_ILLEGAL;
    case (opcode)
      core_pkg::OPC_OP: begin
        if (funct3 == core_pkg::F3_ADD_SUB && funct7 == core_pkg::F7_BASE) begin
          op_d = core_pkg::OP_ADD;
        end else if (funct3 == core_pkg::F3_ADD_SUB && funct7 == core_pkg::F7_SUB) begin
          op_d = core_pkg::OP_SUB;
        end else if (funct3 == core_pkg::F3_XOR && funct7 == core_pkg::F7_BASE) begin
          op_d = core_pkg::OP_XOR;
        end
      end
      core_pkg::OPC_OP_IMM: begin
        if (funct3 == core_pkg::F3_ADDI) begin
          op_d = core_pkg::OP_ADDI;
        end
      end
      core_pkg::OPC_SYSTEM: begin
        if (funct3 == core_pkg::F3_CSRRW) begin
          op_d = core_pkg::OP_CSRRW;
        end else if (funct3 == core_pkg::F3_CSRRS) begin
          op_d = core_pkg::OP_CSRRS;
        end else if (funct3 == core_pkg::F3_PRIV && fetch_instr_i[31:7] == '0) begin
          // ECALL is the all-zero SYSTEM word
          op_d = core_pkg::OP_ECALL;
        end
      end
      default: op_d = core_pkg::OP_ILLEGAL;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dec_valid_o <= 1'b0;
    end else begin
      dec_valid_o <= accept;
    end
  end

  // Decoded entry, consumed by execute in the following cycle
  always_ff @(posedge clk_i) begin
    if (accept) begin
      dec_op_o       <= op_d;
      dec_pc_o       <= fetch_pc_i;
      dec_instr_o    <= fetch_instr_i;
      dec_rd_o       <= fetch_instr_i[11:7];
      dec_rs1_o      <= fetch_instr_i[19:15];
      dec_rs2_o      <= fetch_instr_i[24:20];
      dec_imm_o      <= {{(core_pkg::XLEN-12){fetch_instr_i[31]}}, fetch_instr_i[31:20]};
      dec_csr_addr_o <= fetch_instr_i[31:20];
    end
  end

endmodule

//--- hdl/ex_commit_stage.sv
`timescale 1ns/1ps

module ex_commit_stage (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  // Decoded entry
  input  logic                            dec_valid_i,
  input  core_pkg::op_e                   dec_op_i,
  input  logic [core_pkg::XLEN-1:0]       dec_pc_i,
  input  logic [core_pkg::XLEN-1:0]       dec_instr_i,
  input  logic [core_pkg::REG_ADDR_W-1:0] dec_rd_i,
  input  logic [core_pkg::REG_ADDR_W-1:0] dec_rs1_i,
  input  logic [core_pkg::REG_ADDR_W-1:0] dec_rs2_i,
  input  logic [core_pkg::XLEN-1:0]       dec_imm_i,
  input  logic [core_pkg::CSR_ADDR_W-1:0] dec_csr_addr_i,
  // Register file
  input  logic [core_pkg::XLEN-1:0]       rdata_a_i,
  input  logic [core_pkg::XLEN-1:0]       rdata_b_i,
  output logic [core_pkg::REG_ADDR_W-1:0] raddr_a_o,
  output logic [core_pkg::REG_ADDR_W-1:0] raddr_b_o,
  output logic                            rf_we_o,
  output logic [core_pkg::REG_ADDR_W-1:0] rf_waddr_o,
  output logic [core_pkg::XLEN-1:0]       rf_wdata_o,
  // CSR file
  input  logic [core_pkg::XLEN-1:0]       csr_rdata_i,
  input  logic                            csr_illegal_i,
  input  logic [core_pkg::XLEN-1:0]       mtvec_i,
  output logic                            csr_req_o,
  output core_pkg::op_e                   csr_op_o,
  output logic [core_pkg::CSR_ADDR_W-1:0] csr_addr_o,
  output logic [core_pkg::XLEN-1:0]       csr_wdata_o,
  output logic                            retire_o,
  output logic                            trap_req_o,
  output logic [core_pkg::XLEN-1:0]       trap_cause_csr_o,
  // Decode stall
  output logic                            trap_stall_o,
  // Commit and trap trace
  output logic                            commit_valid_o,
  output logic [core_pkg::XLEN-1:0]       commit_pc_o,
  output logic                            commit_we_o,
  output logic [core_pkg::REG_ADDR_W-1:0] commit_waddr_o,
  output logic [core_pkg::XLEN-1:0]       commit_wdata_o,
  output logic                            trap_valid_o,
  output logic [core_pkg::XLEN-1:0]       trap_pc_o,
  output logic [core_pkg::XLEN-1:0]       trap_cause_o,
  output logic [core_pkg::XLEN-1:0]       trap_tval_o,
  output logic [core_pkg::XLEN-1:0]       trap_redirect_o
);

  logic [core_pkg::XLEN-1:0] result;
  logic [core_pkg::XLEN-1:0] tval;
  logic                      is_csr;
  logic                      illegal;
  logic                      trap;

  assign raddr_a_o = dec_rs1_i;
  assign raddr_b_o = dec_rs2_i;

  // --------------------------------------------------
  // ALU
  // --------------------------------------------------
  always_comb begin
    case (dec_op_i)
      core_pkg::OP_ADD:   result = rdata_a_i + rdata_b_i;
      core_pkg::OP_SUB:   result = rdata_a_i - rdata_b_i;
      core_pkg::OP_XOR:   result = rdata_a_i ^ rdata_b_i;
      core_pkg::OP_ADDI:  result = rdata_a_i + dec_imm_i;
      // CSR ops return the old CSR value
      core_pkg::OP_CSRRW: result = csr_rdata_i;
      core_pkg::OP_CSRRS: result = csr_rdata_i;
      default:            result = '0;
    endcase
  end

  // CSR access, operand always comes from rs1
  assign is_csr      = dec_op_i inside {core_pkg::OP_CSRRW, core_pkg::OP_CSRRS};
  assign csr_req_o   = dec_valid_i & is_csr;
  assign csr_op_o    = dec_op_i;
  assign csr_addr_o  = dec_csr_addr_i;
  assign csr_wdata_o = rdata_a_i;

  // --------------------------------------------------
  // Trap decision
  // --------------------------------------------------
  assign illegal = (dec_op_i == core_pkg::OP_ILLEGAL) | (is_csr & csr_illegal_i);
  assign trap    = dec_valid_i & (illegal | (dec_op_i == core_pkg::OP_ECALL));

  assign trap_req_o       = trap;
  assign trap_stall_o     = trap;
  assign trap_cause_csr_o = illegal ? core_pkg::CAUSE_ILLEGAL_INSTR : core_pkg::CAUSE_ECALL_M;
  assign tval             = illegal ? dec_instr_i : '0;

  // Writeback only for non-trapping entries
  assign retire_o   = dec_valid_i & ~trap;
  assign rf_we_o    = retire_o & (dec_rd_i != '0);
  assign rf_waddr_o = dec_rd_i;
  assign rf_wdata_o = result;

  // --------------------------------------------------
  // Commit and trap reports
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      commit_valid_o <= 1'b0;
      trap_valid_o   <= 1'b0;
    end else begin
      commit_valid_o <= retire_o;
      trap_valid_o   <= trap;
    end
  end

  always_ff @(posedge clk_i) begin
    if (retire_o) begin
      commit_pc_o    <= dec_pc_i;
      commit_we_o    <= rf_we_o;
      commit_waddr_o <= dec_rd_i;
      commit_wdata_o <= result;
    end
    if (trap) begin
      trap_pc_o       <= dec_pc_i;
      trap_cause_o    <= trap_cause_csr_o;
      trap_tval_o     <= tval;
      trap_redirect_o <= mtvec_i;
    end
  end

endmodule

//--- hdl/core_top.sv
`timescale 1ns/1ps

module core_top (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  // Fetch entries
  input  logic                            fetch_valid_i,
  input  logic [core_pkg::XLEN-1:0]       fetch_pc_i,
  input  logic [core_pkg::XLEN-1:0]       fetch_instr_i,
  output logic                            fetch_ready_o,
  // Commit trace
  output logic                            commit_valid_o,
  output logic [core_pkg::XLEN-1:0]       commit_pc_o,
  output logic                            commit_we_o,
  output logic [core_pkg::REG_ADDR_W-1:0] commit_waddr_o,
  output logic [core_pkg::XLEN-1:0]       commit_wdata_o,
  // Trap trace
  output logic                            trap_valid_o,
  output logic [core_pkg::XLEN-1:0]       trap_pc_o,
  output logic [core_pkg::XLEN-1:0]       trap_cause_o,
  output logic [core_pkg::XLEN-1:0]       trap_tval_o,
  output logic [core_pkg::XLEN-1:0]       trap_redirect_o
);

  // --------------------------------------------------
  // Decode to execute
  // --------------------------------------------------
  logic                            dec_valid;
  core_pkg::op_e                   dec_op;
  logic [core_pkg::XLEN-1:0]       dec_pc;
  logic [core_pkg::XLEN-1:0]       dec_instr;
  logic [core_pkg::REG_ADDR_W-1:0] dec_rd;
  logic [core_pkg::REG_ADDR_W-1:0] dec_rs1;
  logic [core_pkg::REG_ADDR_W-1:0] dec_rs2;
  logic [core_pkg::XLEN-1:0]       dec_imm;
  logic [core_pkg::CSR_ADDR_W-1:0] dec_csr_addr;
  logic                            trap_stall;

  // Register file
  logic [core_pkg::REG_ADDR_W-1:0] raddr_a;
  logic [core_pkg::REG_ADDR_W-1:0] raddr_b;
  logic [core_pkg::XLEN-1:0]       rdata_a;
  logic [core_pkg::XLEN-1:0]       rdata_b;
  logic                            rf_we;
  logic [core_pkg::REG_ADDR_W-1:0] rf_waddr;
  logic [core_pkg::XLEN-1:0]       rf_wdata;

  // CSR file
  logic                            csr_req;
  core_pkg::op_e                   csr_op;
  logic [core_pkg::CSR_ADDR_W-1:0] csr_addr;
  logic [core_pkg::XLEN-1:0]       csr_wdata;
  logic [core_pkg::XLEN-1:0]       csr_rdata;
  logic                            csr_illegal;
  logic [core_pkg::XLEN-1:0]       mtvec;
  logic                            retire;
  logic                            trap_req;
  logic [core_pkg::XLEN-1:0]       trap_cause;

  id_stage id_stage_i (
    .trap_stall_i   ( trap_stall   ),
    .dec_valid_o    ( dec_valid    ),
    .dec_op_o       ( dec_op       ),
    .dec_pc_o       ( dec_pc       ),
    .dec_instr_o    ( dec_instr    ),
    .dec_rd_o       ( dec_rd       ),
    .dec_rs1_o      ( dec_rs1      ),
    .dec_rs2_o      ( dec_rs2      ),
    .dec_imm_o      ( dec_imm      ),
    .dec_csr_addr_o ( dec_csr_addr ),
    .*
  );

  regfile regfile_i (
    .clk_i,
    .rst_ni,
    .raddr_a_i ( raddr_a  ),
    .raddr_b_i ( raddr_b  ),
    .we_i      ( rf_we    ),
    .waddr_i   ( rf_waddr ),
    .wdata_i   ( rf_wdata ),
    .rdata_a_o ( rdata_a  ),
    .rdata_b_o ( rdata_b  )
  );

  csr_regfile csr_regfile_i (
    .clk_i,
    .rst_ni,
    .csr_req_i     ( csr_req     ),
    .csr_op_i      ( csr_op      ),
    .csr_addr_i    ( csr_addr    ),
    .csr_wdata_i   ( csr_wdata   ),
    .retire_i      ( retire      ),
    .trap_req_i    ( trap_req    ),
    .trap_pc_i     ( dec_pc      ),
    .trap_cause_i  ( trap_cause  ),
    .csr_rdata_o   ( csr_rdata   ),
    .csr_illegal_o ( csr_illegal ),
    .mtvec_o       ( mtvec       )
  );

  // Commit and trap trace ports connect by name
  ex_commit_stage ex_commit_stage_i (
    .dec_valid_i      ( dec_valid    ),
    .dec_op_i         ( dec_op       ),
    .dec_pc_i         ( dec_pc       ),
    .dec_instr_i      ( dec_instr    ),
    .dec_rd_i         ( dec_rd       ),
    .dec_rs1_i        ( dec_rs1      ),
    .dec_rs2_i        ( dec_rs2      ),
    .dec_imm_i        ( dec_imm      ),
    .dec_csr_addr_i   ( dec_csr_addr ),
    .rdata_a_i        ( rdata_a      ),
    .rdata_b_i        ( rdata_b      ),
    .raddr_a_o        ( raddr_a      ),
    .raddr_b_o        ( raddr_b      ),
    .rf_we_o          ( rf_we        ),
    .rf_waddr_o       ( rf_waddr     ),
    .rf_wdata_o       ( rf_wdata     ),
    .csr_rdata_i      ( csr_rdata    ),
    .csr_illegal_i    ( csr_illegal  ),
    .mtvec_i          ( mtvec        ),
    .csr_req_o        ( csr_req      ),
    .csr_op_o         ( csr_op       ),
    .csr_addr_o       ( csr_addr     ),
    .csr_wdata_o      ( csr_wdata    ),
    .retire_o         ( retire       ),
    .trap_req_o       ( trap_req     ),
    .trap_cause_csr_o ( trap_cause   ),
    .trap_stall_o     ( trap_stall   ),
    .*
  );

endmodule

//--- verif/core_assertions.sv
`timescale 1ns/1ps

module core_assertions (
  input logic clk_i,
  input logic rst_ni,
  input logic fetch_valid_i,
  input logic fetch_ready_i,
  input logic commit_valid_i,
  input logic trap_valid_i
);

  int unsigned fail_cnt = 0;
  logic        accept;

  assign accept = fetch_valid_i & fetch_ready_i;

  // --------------------------------------------------
  // Reset state
  // --------------------------------------------------
  reset_idle_a: assert property (@(posedge clk_i)
    !rst_ni |-> fetch_ready_i && !commit_valid_i && !trap_valid_i)
    else begin
      $error("trace ports not idle or fetch not ready during reset");
      fail_cnt++;
    end

  // --------------------------------------------------
  // Handshake and commit latency
  // --------------------------------------------------
  one_report_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(commit_valid_i && trap_valid_i))
    else begin
      $error("commit and trap reported in the same cycle");
      fail_cnt++;
    end

  // Report one cycle after the accepting edge, seen two samples later
  latency_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (commit_valid_i || trap_valid_i) == $past(accept, 2))
    else begin
      $error("report does not follow an accepted entry after one cycle");
      fail_cnt++;
    end

  // Fetch is held off only in the cycle a trap executes
  ready_drop_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    trap_valid_i == !$past(fetch_ready_i))
    else begin
      $error("fetch ready dropped outside the cycle before a trap report");
      fail_cnt++;
    end

endmodule

//--- verif/core_tb.sv
`timescale 1ns/1ps

module core_tb;

  logic                            clk_i = 1'b0;
  logic                            rst_ni;
  logic                            fetch_valid_i;
  logic [core_pkg::XLEN-1:0]       fetch_pc_i;
  logic [core_pkg::XLEN-1:0]       fetch_instr_i;
  logic                            fetch_ready_o;
  logic                            commit_valid_o;
  logic                            commit_we_o;
  logic [core_pkg::XLEN-1:0]       commit_pc_o;
  logic [core_pkg::XLEN-1:0]       commit_wdata_o;
  logic [core_pkg::REG_ADDR_W-1:0] commit_waddr_o;
  logic                            trap_valid_o;
  logic [core_pkg::XLEN-1:0]       trap_pc_o;
  logic [core_pkg::XLEN-1:0]       trap_cause_o;
  logic [core_pkg::XLEN-1:0]       trap_tval_o;
  logic [core_pkg::XLEN-1:0]       trap_redirect_o;

  // Reference model of architectural state
  logic [31:0] m_regs [0:31];
  logic [31:0] m_csr [logic [11:0]];
  logic [31:0] next_pc;

  // Expected reports, oldest first
  bit          exp_trap_q  [$];
  logic [31:0] exp_pc_q    [$];
  bit          exp_we_q    [$];
  logic [31:0] exp_rd_q    [$];
  logic [31:0] exp_val_q   [$];
  logic [31:0] exp_tval_q  [$];
  logic [31:0] exp_redir_q [$];

  int errors;
  int test_start;
  int tests_run;
  int tests_clean;

  core_top uut (
    .clk_i           ( clk_i           ),
    .rst_ni          ( rst_ni          ),
    .fetch_valid_i   ( fetch_valid_i   ),
    .fetch_pc_i      ( fetch_pc_i      ),
    .fetch_instr_i   ( fetch_instr_i   ),
    .fetch_ready_o   ( fetch_ready_o   ),
    .commit_valid_o  ( commit_valid_o  ),
    .commit_pc_o     ( commit_pc_o     ),
    .commit_we_o     ( commit_we_o     ),
    .commit_waddr_o  ( commit_waddr_o  ),
    .commit_wdata_o  ( commit_wdata_o  ),
    .trap_valid_o    ( trap_valid_o    ),
    .trap_pc_o       ( trap_pc_o       ),
    .trap_cause_o    ( trap_cause_o    ),
    .trap_tval_o     ( trap_tval_o     ),
    .trap_redirect_o ( trap_redirect_o )
  );

  bind core_top core_assertions core_assertions_i (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .fetch_valid_i  ( fetch_valid_i  ),
    .fetch_ready_i  ( fetch_ready_o  ),
    .commit_valid_i ( commit_valid_o ),
    .trap_valid_i   ( trap_valid_o   )
  );

  always #4 clk_i = ~clk_i;

  function automatic int total_errors();
    return errors + int'(uut.core_assertions_i.fail_cnt);
  endfunction

  function automatic int rand_gap();
    return ($urandom_range(3, 0) == 0) ? int'($urandom_range(2, 1)) : 0;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("FAIL %0t ns %s expected %08h got %08h", $time, name, exp, got);
      errors++;
    end
  endtask

  // --------------------------------------------------
  // Report checker
  // --------------------------------------------------
  task automatic check_report();
    bit          is_trap;
    logic [31:0] pc;
    bit          we;
    logic [31:0] rd;
    logic [31:0] val;
    logic [31:0] tval;
    logic [31:0] redir;
    is_trap = exp_trap_q.pop_front();
    pc      = exp_pc_q.pop_front();
    we      = exp_we_q.pop_front();
    rd      = exp_rd_q.pop_front();
    val     = exp_val_q.pop_front();
    tval    = exp_tval_q.pop_front();
    redir   = exp_redir_q.pop_front();
    assert (trap_valid_o == is_trap) else begin
      $display("ERROR %0t ns: wrong report kind for the entry at pc %08h", $time, pc);
      errors++;
    end
    if (commit_valid_o && !is_trap) begin
      check_val("commit_pc_o", commit_pc_o, pc);
      check_val("commit_we_o", 32'(commit_we_o), 32'(we));
      check_val("commit_waddr_o", 32'(commit_waddr_o), rd);
      check_val("commit_wdata_o", commit_wdata_o, val);
    end else if (trap_valid_o && is_trap) begin
      check_val("trap_pc_o", trap_pc_o, pc);
      check_val("trap_cause_o", trap_cause_o, val);
      check_val("trap_tval_o", trap_tval_o, tval);
      check_val("trap_redirect_o", trap_redirect_o, redir);
    end
  endtask

  always @(negedge clk_i) begin
    if (rst_ni && (commit_valid_o || trap_valid_o)) begin
      if (exp_trap_q.size() == 0) begin
        $display("ERROR %0t ns: the DUT reported with no accepted entry pending", $time);
        errors++;
      end else begin
        check_report();
      end
    end
  end

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  task automatic send(input logic [31:0] word, input int gap);
    int waited;
    fetch_valid_i = 1'b0;
    repeat (gap) begin
      @(posedge clk_i);
      #1;
    end
    fetch_valid_i = 1'b1;
    fetch_pc_i    = next_pc;
    fetch_instr_i = word;
    waited        = 0;
    @(negedge clk_i);
    while (!fetch_ready_o && waited < 20) begin
      @(negedge clk_i);
      waited++;
    end
    if (!fetch_ready_o) begin
      $display("ERROR %0t ns: entry at pc %08h was never accepted", $time, next_pc);
      errors++;
    end
    @(posedge clk_i);
    #1;
    fetch_valid_i = 1'b0;
    next_pc       = next_pc + 32'd4;
  endtask

  // Predict the report for one entry, update the model, then send it
  task automatic issue_word(input core_pkg::op_e op, input logic [31:0] word, input int gap);
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [11:0] csr;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] val;
    logic [31:0] cause;
    logic [31:0] tval;
    bit          trap;
    bit          wr;
    rd    = word[11:7];
    rs1   = word[19:15];
    csr   = word[31:20];
    a     = m_regs[rs1];
    b     = m_regs[word[24:20]];
    val   = '0;
    cause = '0;
    tval  = '0;
    trap  = 1'b0;
    case (op)
      core_pkg::OP_ADD:  val = a + b;
      core_pkg::OP_SUB:  val = a - b;
      core_pkg::OP_XOR:  val = a ^ b;
      core_pkg::OP_ADDI: val = a + {{20{word[31]}}, word[31:20]};
      core_pkg::OP_CSRRW, core_pkg::OP_CSRRS: begin
        wr = (op == core_pkg::OP_CSRRW) || (rs1 != 5'd0);
        if (!m_csr.exists(csr) || (wr && csr == core_pkg::CSR_MINSTRET)) begin
          trap  = 1'b1;
          cause = core_pkg::CAUSE_ILLEGAL_INSTR;
          tval  = word;
        end else begin
          val = m_csr[csr];
          if (wr) begin
            m_csr[csr] = (op == core_pkg::OP_CSRRW) ? a : (val | a);
          end
        end
      end
      core_pkg::OP_ECALL: begin
        trap  = 1'b1;
        cause = core_pkg::CAUSE_ECALL_M;
      end
      default: begin
        trap  = 1'b1;
        cause = core_pkg::CAUSE_ILLEGAL_INSTR;
        tval  = word;
      end
    endcase
    exp_trap_q.push_back(trap);
    exp_pc_q.push_back(next_pc);
    exp_we_q.push_back(!trap && rd != 5'd0);
    exp_rd_q.push_back(32'(rd));
    exp_val_q.push_back(trap ? cause : val);
    exp_tval_q.push_back(tval);
    exp_redir_q.push_back(m_csr[core_pkg::CSR_MTVEC]);
    if (trap) begin
      m_csr[core_pkg::CSR_MEPC]   = next_pc;
      m_csr[core_pkg::CSR_MCAUSE] = cause;
    end else begin
      m_csr[core_pkg::CSR_MINSTRET] = m_csr[core_pkg::CSR_MINSTRET] + 32'd1;
      if (rd != 5'd0) begin
        m_regs[rd] = val;
      end
    end
    send(word, gap);
  endtask

  task automatic issue(input core_pkg::op_e op, input logic [4:0] rd, input logic [4:0] rs1,
                       input logic [4:0] rs2, input logic [11:0] imm, input int gap);
    logic [31:0] word;
    case (op)
      core_pkg::OP_ADD:
        word = {core_pkg::F7_BASE, rs2, rs1, core_pkg::F3_ADD_SUB, rd, core_pkg::OPC_OP};
      core_pkg::OP_SUB:
        word = {core_pkg::F7_SUB, rs2, rs1, core_pkg::F3_ADD_SUB, rd, core_pkg::OPC_OP};
      core_pkg::OP_XOR:
        word = {core_pkg::F7_BASE, rs2, rs1, core_pkg::F3_XOR, rd, core_pkg::OPC_OP};
      core_pkg::OP_ADDI:  word = {imm, rs1, core_pkg::F3_ADDI, rd, core_pkg::OPC_OP_IMM};
      core_pkg::OP_CSRRW: word = {imm, rs1, core_pkg::F3_CSRRW, rd, core_pkg::OPC_SYSTEM};
      core_pkg::OP_CSRRS: word = {imm, rs1, core_pkg::F3_CSRRS, rd, core_pkg::OPC_SYSTEM};
      default:            word = {25'd0, core_pkg::OPC_SYSTEM};
    endcase
    issue_word(op, word, gap);
  endtask

  task automatic end_test(input string name);
    int waited;
    int found;
    waited = 0;
    while (exp_trap_q.size() != 0 && waited < 40) begin
      @(negedge clk_i);
      waited++;
    end
    if (exp_trap_q.size() != 0) begin
      $display("ERROR %0t ns: %0d expected reports never arrived", $time, exp_trap_q.size());
      errors++;
    end
    @(negedge clk_i);
    found = total_errors() - test_start;
    tests_run++;
    if (found == 0) begin
      tests_clean++;
      $display("test %-10s ok", name);
    end else begin
      $display("test %-10s %0d errors", name, found);
    end
    test_start = total_errors();
    // Next stimulus starts just after a rising edge
    @(posedge clk_i);
    #1;
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin
    logic [31:0] word;
    void'($urandom(32'h2f7c6751));
    rst_ni        = 1'b0;
    fetch_valid_i = 1'b0;
    fetch_pc_i    = '0;
    fetch_instr_i = '0;
    errors        = 0;
    test_start    = 0;
    tests_run     = 0;
    tests_clean   = 0;
    next_pc       = 32'h0000_1000;
    for (int i = 0; i < 32; i++) begin
      m_regs[i] = '0;
    end
    m_csr[core_pkg::CSR_MSCRATCH] = '0;
    m_csr[core_pkg::CSR_MTVEC]    = '0;
    m_csr[core_pkg::CSR_MEPC]     = '0;
    m_csr[core_pkg::CSR_MCAUSE]   = '0;
    m_csr[core_pkg::CSR_MINSTRET] = '0;

    repeat (3) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_val("commit_valid_o", 32'(commit_valid_o), 32'd0);
    check_val("trap_valid_o", 32'(trap_valid_o), 32'd0);
    check_val("fetch_ready_o", 32'(fetch_ready_o), 32'd1);
    end_test("reset");

    // Random ALU stream, small register window so results get reused
    for (int n = 0; n < 40; n++) begin
      issue(core_pkg::op_e'($urandom_range(3, 0)), 5'($urandom_range(7, 0)),
            5'($urandom_range(7, 0)), 5'($urandom_range(7, 0)), 12'($urandom()), rand_gap());
    end
    issue(core_pkg::OP_ADD, 5'd5, 5'd0, 5'd0, 12'd0, 0);
    end_test("alu");

    // Back to back, with one trap in the middle
    for (int n = 0; n < 12; n++) begin
      issue(core_pkg::op_e'($urandom_range(3, 0)), 5'($urandom_range(7, 0)),
            5'($urandom_range(7, 0)), 5'($urandom_range(7, 0)), 12'($urandom()), 0);
      if (n == 5) begin
        issue(core_pkg::OP_ECALL, 5'd0, 5'd0, 5'd0, 12'd0, 0);
      end
    end
    end_test("latency");

    issue(core_pkg::OP_ADDI, 5'd6, 5'd0, 5'd0, 12'($urandom()), 0);
    issue(core_pkg::OP_CSRRW, 5'd7, 5'd6, 5'd0, core_pkg::CSR_MSCRATCH, 0);
    issue(core_pkg::OP_ADDI, 5'd8, 5'd0, 5'd0, 12'($urandom()), 1);
    issue(core_pkg::OP_CSRRW, 5'd9, 5'd8, 5'd0, core_pkg::CSR_MSCRATCH, 0);
    issue(core_pkg::OP_CSRRS, 5'd10, 5'd6, 5'd0, core_pkg::CSR_MSCRATCH, 0);
    issue(core_pkg::OP_CSRRS, 5'd11, 5'd0, 5'd0, core_pkg::CSR_MSCRATCH, 0);
    issue(core_pkg::OP_CSRRS, 5'd12, 5'd0, 5'd0, core_pkg::CSR_MINSTRET, 0);
    issue(core_pkg::OP_CSRRW, 5'd0, 5'd6, 5'd0, core_pkg::CSR_MINSTRET, 0);
    issue(core_pkg::OP_CSRRS, 5'd13, 5'd0, 5'd0, core_pkg::CSR_MINSTRET, 0);
    issue(core_pkg::OP_CSRRS, 5'd14, 5'd0, 5'd0, 12'h7C0, 0);
    end_test("csr");

    issue(core_pkg::OP_ADDI, 5'd13, 5'd0, 5'd0, 12'($urandom()) & 12'h7FC, 0);
    issue(core_pkg::OP_CSRRW, 5'd0, 5'd13, 5'd0, core_pkg::CSR_MTVEC, 0);
    issue(core_pkg::OP_ECALL, 5'd0, 5'd0, 5'd0, 12'd0, 0);
    issue(core_pkg::OP_ADDI, 5'd15, 5'd13, 5'd0, 12'($urandom()), 0);
    issue(core_pkg::OP_CSRRS, 5'd16, 5'd0, 5'd0, core_pkg::CSR_MEPC, 0);
    issue(core_pkg::OP_CSRRS, 5'd17, 5'd0, 5'd0, core_pkg::CSR_MCAUSE, 0);
    // Custom-0 opcode is never decoded
    word = ($urandom() & 32'hFFFF_FF80) | 32'h0000_000B;
    issue_word(core_pkg::OP_ILLEGAL, word, 0);
    issue(core_pkg::OP_XOR, 5'd18, 5'd15, 5'd16, 12'd0, 0);
    issue(core_pkg::OP_CSRRS, 5'd19, 5'd0, 5'd0, core_pkg::CSR_MEPC, 0);
    issue(core_pkg::OP_CSRRS, 5'd20, 5'd0, 5'd0, core_pkg::CSR_MCAUSE, 0);
    end_test("traps");

    $display("tests run %0d, clean %0d, errors %0d", tests_run, tests_clean, total_errors());
    if (total_errors() == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- vlog.f
hdl/core_pkg.sv
hdl/regfile.sv
hdl/csr_regfile.sv
hdl/id_stage.sv
hdl/ex_commit_stage.sv
hdl/core_top.sv
verif/core_assertions.sv
verif/core_tb.sv

//--- run_verilator.sh
#!/usr/bin/env bash
# Build the core testbench with Verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module core_tb \
  -f vlog.f -o core_sim || { echo "Verilator build failed"; exit 1; }

sim_out="$(./obj_dir/core_sim +verilator+error+limit+1000)"
echo "$sim_out"
grep -qF '*** TEST PASSED ***' <<< "$sim_out" && exit 0 || exit 1
